// ==== logic/rp_pkg.sv ====
// shared bus definitions
// - bus address and data types
// - region field position, count and region indices
// - register offsets of the housekeeping and mixer blocks

package rp_pkg;

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  typedef logic [31:0] bus_addr_t;  // byte address from the master
  typedef logic [31:0] bus_data_t;  // read and write data

  localparam int REGION_LSB = 20;  // 1 MiB regions
  localparam int REGION_W   = 3;   // addr[22:20]
  localparam int N_REGIONS  = 8;
  localparam int OFS_W      = 20;  // offset inside a region

  typedef logic [REGION_W-1:0] region_t;

  localparam region_t REGION_HK  = 3'd0;  // housekeeping
  localparam region_t REGION_MIX = 3'd2;  // dc level and loopback

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  // housekeeping, region 0
  localparam logic [OFS_W-1:0] HK_ID_OFS   = 20'h00;
  localparam logic [OFS_W-1:0] HK_LED_OFS  = 20'h30;
  localparam bus_data_t        HK_ID_VALUE = 32'h5250_0001;  // read only

  // mixer, region 2
  localparam logic [OFS_W-1:0] MIX_LVL_A_OFS = 20'h00;  // ch a dc level
  localparam logic [OFS_W-1:0] MIX_LVL_B_OFS = 20'h04;  // ch b dc level
  localparam logic [OFS_W-1:0] MIX_LOOP_OFS  = 20'h08;  // loopback enables

endpackage

// ==== logic/sys_bus_if.sv ====
// one slave port of the system bus
// - offset, write data and strobes from the decoder
// - registered response from the slave

`timescale 1ns/1ps

interface sys_bus_if import rp_pkg::*; ();

  logic [OFS_W-1:0] addr;   // offset within the region
  bus_data_t        wdata;
  logic             wen;    // one cycle write strobe
  logic             ren;    // one cycle read strobe
  bus_data_t        rdata;  // valid with ack
  logic             ack;    // one cycle after the strobe
  logic             err;    // unmapped offset

  // decoder side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  // register block side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

// ==== logic/sys_bus_decoder.sv ====
// system bus decoder
// - region decode from the address field
// - strobe fan-out to the populated slaves
// - response mux in the ack cycle, local ack for empty regions

`timescale 1ns/1ps

module sys_bus_decoder import rp_pkg::*; (
  input  logic      adc_clk,  // bus runs on the adc clock
  input  logic      rst_n_i,  // async, active low
  input  bus_addr_t addr_i,   // full byte address
  input  bus_data_t wdata_i,
  input  logic      wen_i,    // write strobe
  input  logic      ren_i,    // read strobe
  output bus_data_t rdata_o,
  output logic      ack_o,
  output logic      err_o,
  sys_bus_if.master hk_bus,   // region 0
  sys_bus_if.master mix_bus   // region 2
);

  region_t              region;    // region of the live address
  logic [N_REGIONS-1:0] sel;       // one-hot select
  logic                 strobe;    // any access
  region_t              region_q;  // region of the last strobe
  logic                 pend_q;    // this is the ack cycle

  assign region = addr_i[REGION_LSB +: REGION_W];
  assign sel    = {{(N_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe = wen_i | ren_i;

  //////////////////////////////////////////////////
  // request fan-out
  //////////////////////////////////////////////////

  assign hk_bus.addr   = addr_i[OFS_W-1:0];  // offset only
  assign hk_bus.wdata  = wdata_i;
  assign hk_bus.wen    = wen_i & sel[REGION_HK];
  assign hk_bus.ren    = ren_i & sel[REGION_HK];

  assign mix_bus.addr  = addr_i[OFS_W-1:0];
  assign mix_bus.wdata = wdata_i;
  assign mix_bus.wen   = wen_i & sel[REGION_MIX];
  assign mix_bus.ren   = ren_i & sel[REGION_MIX];

  // remember where the access went
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      region_q <= REGION_HK;
      pend_q   <= 1'b0;
    end
    else
    begin
      pend_q <= strobe;           // ack always follows one cycle later
      if (strobe)
        region_q <= region;
    end
  end

  //////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////

  always_comb
  begin
    rdata_o = '0;
    ack_o   = 1'b0;
    err_o   = 1'b0;
    if (pend_q)
    begin
      case (region_q)
        REGION_HK:
        begin
          rdata_o = hk_bus.rdata;
          ack_o   = hk_bus.ack;
          err_o   = hk_bus.err;
        end
        REGION_MIX:
        begin
          rdata_o = mix_bus.rdata;
          ack_o   = mix_bus.ack;
          err_o   = mix_bus.err;
        end
        default: ack_o = 1'b1;    // empty region, zero data, no error
      endcase
    end
  end

endmodule

// ==== logic/housekeeping_regs.sv ====
// housekeeping registers, region 0
// - fixed ID word, read only
// - LED register

`timescale 1ns/1ps

module housekeeping_regs import rp_pkg::*; #(
  parameter int LED_W = 8
) (
  input  logic             adc_clk,
  input  logic             rst_n_i,  // async, active low
  sys_bus_if.slave         bus,
  output logic [LED_W-1:0] led_o     // straight from the register
);

  logic      strobe;  // read or write
  logic      hit;     // offset is mapped
  bus_data_t rd_val;  // read mux

  assign strobe = bus.wen | bus.ren;

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (bus.addr)
      HK_ID_OFS:  rd_val = HK_ID_VALUE;          // writes land nowhere
      HK_LED_OFS: rd_val = bus_data_t'(led_o);
      default:    hit    = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      led_o   <= '0;
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end
    else
    begin
      bus.ack <= strobe;
      bus.err <= strobe & ~hit;
      if (bus.wen && bus.addr == HK_LED_OFS)
        led_o <= bus.wdata[LED_W-1:0];   // low bits only
    end
  end

  // read data, zero on writes and holes
  always_ff @(posedge adc_clk)
  begin
    if (strobe)
      bus.rdata <= bus.ren ? rd_val : '0;
  end

endmodule

// ==== logic/adc_frontend.sv ====
// ADC input stage
// - input registers for both channels
// - negative slope code to two's complement

`timescale 1ns/1ps

module adc_frontend #(
  parameter int DAT_W = 14
) (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  logic        [DAT_W-1:0] adc_a_i,  // raw, negative slope
  input  logic        [DAT_W-1:0] adc_b_i,
  output logic signed [DAT_W-1:0] adc_a_o,  // two's complement
  output logic signed [DAT_W-1:0] adc_b_o
);

  localparam logic [DAT_W-1:0] RAW_ZERO = {1'b0, {(DAT_W-1){1'b1}}};  // 0x1fff at 14 bits

  logic [DAT_W-1:0] raw_a, raw_b;

  // keep msb, flip the rest
  function automatic logic signed [DAT_W-1:0] to_signed(input logic [DAT_W-1:0] raw);
    return {raw[DAT_W-1], ~raw[DAT_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      raw_a <= RAW_ZERO;
      raw_b <= RAW_ZERO;
    end
    else
    begin
      raw_a <= adc_a_i;
      raw_b <= adc_b_i;
    end
  end

  assign adc_a_o = to_signed(raw_a);
  assign adc_b_o = to_signed(raw_b);

endmodule

// ==== logic/dac_mix_regs.sv ====
// mixer registers, region 2
// - dc level per channel, signed
// - loopback enable per channel

`timescale 1ns/1ps

module dac_mix_regs import rp_pkg::*; #(
  parameter int DAT_W = 14
) (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,    // async, active low
  sys_bus_if.slave                bus,
  output logic signed [DAT_W-1:0] lvl_a_o,    // ch a level
  output logic signed [DAT_W-1:0] lvl_b_o,    // ch b level
  output logic        [1:0]       loop_en_o   // [0] ch a, [1] ch b
);

  logic      strobe;
  logic      hit;     // mapped offset
  bus_data_t rd_val;

  assign strobe = bus.wen | bus.ren;

  // levels read back sign extended
  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (bus.addr)
      MIX_LVL_A_OFS: rd_val = {{($bits(bus_data_t)-DAT_W){lvl_a_o[DAT_W-1]}}, lvl_a_o};
      MIX_LVL_B_OFS: rd_val = {{($bits(bus_data_t)-DAT_W){lvl_b_o[DAT_W-1]}}, lvl_b_o};
      MIX_LOOP_OFS:  rd_val = bus_data_t'(loop_en_o);
      default:       hit    = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lvl_a_o   <= '0;
      lvl_b_o   <= '0;
      loop_en_o <= 2'b00;
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
    end
    else
    begin
      bus.ack <= strobe;
      bus.err <= strobe & ~hit;
      if (bus.wen)
      begin
        case (bus.addr)
          MIX_LVL_A_OFS: lvl_a_o   <= bus.wdata[DAT_W-1:0];  // low bits hold the sign
          MIX_LVL_B_OFS: lvl_b_o   <= bus.wdata[DAT_W-1:0];
          MIX_LOOP_OFS:  loop_en_o <= bus.wdata[1:0];
          default:       ;                                   // err flagged above
        endcase
      end
    end
  end

  // read data, zero on writes and holes
  always_ff @(posedge adc_clk)
  begin
    if (strobe)
      bus.rdata <= bus.ren ? rd_val : '0;
  end

endmodule

// ==== logic/dac_output.sv ====
// DAC output stage
// - level plus optional adc loopback, one guard bit
// - saturation to DAT_W bits
// - two's complement to negative slope code, output registers

`timescale 1ns/1ps

module dac_output #(
  parameter int DAT_W = 14
) (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  logic signed [DAT_W-1:0] adc_a_i,    // converted samples
  input  logic signed [DAT_W-1:0] adc_b_i,
  input  logic signed [DAT_W-1:0] lvl_a_i,    // dc levels
  input  logic signed [DAT_W-1:0] lvl_b_i,
  input  logic        [1:0]       loop_en_i,
  output logic        [DAT_W-1:0] dac_a_o,    // negative slope code
  output logic        [DAT_W-1:0] dac_b_o
);

  localparam logic [DAT_W-1:0] DAC_ZERO = {1'b0, {(DAT_W-1){1'b1}}};  // code for 0

  // level + sample, sample only when looped back
  function automatic logic signed [DAT_W:0] chan_sum(
    input logic signed [DAT_W-1:0] lvl,
    input logic signed [DAT_W-1:0] smp,
    input logic                    en
  );
    logic signed [DAT_W-1:0] add;
    add = en ? smp : {DAT_W{1'b0}};
    return lvl + add;          // sign extended into the guard bit
  endfunction

  // clip on overflow, then back to neg slope
  function automatic logic [DAT_W-1:0] to_dac(input logic signed [DAT_W:0] sum);
    logic [DAT_W-1:0] sat;
    if (sum[DAT_W] != sum[DAT_W-1])
      sat = {sum[DAT_W], {(DAT_W-1){~sum[DAT_W]}}};  // full scale, keep sign
    else
      sat = sum[DAT_W-1:0];
    return {sat[DAT_W-1], ~sat[DAT_W-2:0]};
  endfunction

  logic signed [DAT_W:0] sum_a, sum_b;

  assign sum_a = chan_sum(lvl_a_i, adc_a_i, loop_en_i[0]);
  assign sum_b = chan_sum(lvl_b_i, adc_b_i, loop_en_i[1]);

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_a_o <= DAC_ZERO;
      dac_b_o <= DAC_ZERO;
    end
    else
    begin
      dac_a_o <= to_dac(sum_a);
      dac_b_o <= to_dac(sum_b);
    end
  end

endmodule

// ==== logic/rp_analog_top.sv ====
// analog data path top level
// - system bus decoder and its two register slaves
// - adc input stage, mixer registers, dac output stage

`timescale 1ns/1ps

module rp_analog_top import rp_pkg::*; #(
  parameter int DAT_W = 14,  // adc and dac sample width
  parameter int LED_W = 8
) (
  input  logic             adc_clk,
  input  logic             rst_n_i,      // async, active low
  // adc
  input  logic [DAT_W-1:0] adc_dat_a_i,  // ch a, negative slope
  input  logic [DAT_W-1:0] adc_dat_b_i,  // ch b
  // system bus
  input  bus_addr_t        sys_addr_i,
  input  bus_data_t        sys_wdata_i,
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  output bus_data_t        sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o,
  // dac and leds
  output logic [DAT_W-1:0] dac_a_o,
  output logic [DAT_W-1:0] dac_b_o,
  output logic [LED_W-1:0] led_o
);

  logic signed [DAT_W-1:0] adc_a, adc_b;  // two's complement samples
  logic signed [DAT_W-1:0] lvl_a, lvl_b;
  logic        [1:0]       loop_en;

  sys_bus_if hk_bus ();   // region 0
  sys_bus_if mix_bus ();  // region 2

  //////////////////////////////////////////////////
  // register bus
  //////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk (adc_clk),     .rst_n_i (rst_n_i),
    .addr_i  (sys_addr_i),  .wdata_i (sys_wdata_i),
    .wen_i   (sys_wen_i),   .ren_i   (sys_ren_i),
    .rdata_o (sys_rdata_o), .ack_o   (sys_ack_o),   .err_o (sys_err_o),
    .hk_bus  (hk_bus.master),
    .mix_bus (mix_bus.master)
  );

  housekeeping_regs #(.LED_W(LED_W)) i_hk (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i), .bus (hk_bus.slave), .led_o (led_o)
  );

  //////////////////////////////////////////////////
  // analog path
  //////////////////////////////////////////////////

  adc_frontend #(.DAT_W(DAT_W)) i_adc (
    .adc_clk (adc_clk),     .rst_n_i (rst_n_i),
    .adc_a_i (adc_dat_a_i), .adc_b_i (adc_dat_b_i),
    .adc_a_o (adc_a),       .adc_b_o (adc_b)
  );

  dac_mix_regs #(.DAT_W(DAT_W)) i_mix (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i), .bus (mix_bus.slave),
    .lvl_a_o (lvl_a),   .lvl_b_o (lvl_b),   .loop_en_o (loop_en)
  );

  dac_output #(.DAT_W(DAT_W)) i_dac (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .adc_a_i (adc_a),   .adc_b_i (adc_b),
    .lvl_a_i (lvl_a),   .lvl_b_i (lvl_b),   .loop_en_i (loop_en),
    .dac_a_o (dac_a_o), .dac_b_o (dac_b_o)
  );

endmodule

// ==== testbench/tb_tasks.svh ====
// testbench helpers, included into the testbench top module
// - galois lfsr random source
// - models of the code conversions and the dac mixing
// - compare tasks, one per kind of result
// - bus access tasks with ack timing check

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////
// random source
//////////////////////////////////////////////////

logic [31:0] lfsr_q = LFSR_SEED;

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        lsb;
  int          i;
  val = '0;
  for (i = 0; i < n; i++)
  begin
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb)
      lfsr_q = lfsr_q ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    val = {val[30:0], lsb};
  end
  return val;
endfunction

function automatic code_t rand_code();
  logic [31:0] v;
  v = rand_bits(DAT_W);
  return v[DAT_W-1:0];
endfunction

// signed level, full range
function automatic int rand_level();
  int v;
  v = int'(rand_code());
  if (v > VAL_MAX)
    v = v - (2 ** DAT_W);
  return v;
endfunction

//////////////////////////////////////////////////
// models
//////////////////////////////////////////////////

// negative slope: code 0 is full scale positive
function automatic int code_to_val(input code_t code);
  int c;
  c = int'(code);
  return VAL_MAX - c;
endfunction

function automatic code_t val_to_code(input int v);
  int c;
  c = VAL_MAX - v;
  return c[DAT_W-1:0];
endfunction

function automatic int clip_val(input int v);
  if (v > VAL_MAX)
    return VAL_MAX;
  if (v < VAL_MIN)
    return VAL_MIN;
  return v;
endfunction

// level plus looped adc sample, clipped, re-encoded
function automatic code_t expect_dac(input int lvl, input code_t adc, input logic en);
  int sum;
  sum = lvl;
  if (en)
    sum = sum + code_to_val(adc);
  return val_to_code(clip_val(sum));
endfunction

function automatic bus_addr_t reg_addr(input region_t r, input logic [OFS_W-1:0] ofs);
  bus_addr_t a;
  a = '0;
  a[REGION_LSB +: REGION_W] = r;
  a[OFS_W-1:0]              = ofs;
  return a;
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic compare_data(input string name, input bus_data_t got, input bus_data_t exp);
  if (got !== exp)
    fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
endtask

task automatic compare_dac(input string name, input code_t got, input code_t exp);
  if (got !== exp)
    fail_run($sformatf("MISMATCH %s got 0x%04h expected 0x%04h", name, got, exp));
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
  if (got !== exp)
    fail_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

//////////////////////////////////////////////////
// bus access
//////////////////////////////////////////////////

// one strobe, ack expected exactly one cycle later
task automatic bus_access(input logic wr, input bus_addr_t addr, input bus_data_t wdata,
                          output bus_data_t rdata, output logic err);
  @(posedge adc_clk);
  sys_addr_i  <= addr;
  sys_wdata_i <= wdata;
  sys_wen_i   <= wr;
  sys_ren_i   <= ~wr;
  @(negedge adc_clk);
  if (sys_ack_o !== 1'b0)
    fail_run($sformatf("bus ack came in the strobe cycle, address 0x%08h", addr));
  @(posedge adc_clk);
  sys_wen_i <= 1'b0;              // strobe lasts one cycle
  sys_ren_i <= 1'b0;
  @(negedge adc_clk);
  if (sys_ack_o !== 1'b1)
    fail_run($sformatf("no bus ack one cycle after the strobe, address 0x%08h", addr));
  rdata = sys_rdata_o;
  err   = sys_err_o;
endtask

task automatic bus_write(input bus_addr_t addr, input bus_data_t wdata, output logic err);
  bus_data_t rd;
  bus_access(1'b1, addr, wdata, rd, err);
endtask

task automatic bus_read(input bus_addr_t addr, output bus_data_t rdata, output logic err);
  bus_access(1'b0, addr, '0, rdata, err);
endtask

// write that must not flag err
task automatic write_ok(input bus_addr_t addr, input bus_data_t wdata);
  logic err;
  bus_write(addr, wdata, err);
  compare_flag("sys_err_o", err, 1'b0);
endtask

task automatic read_check(input bus_addr_t addr, input bus_data_t exp);
  bus_data_t rd;
  logic      err;
  bus_read(addr, rd, err);
  compare_flag("sys_err_o", err, 1'b0);
  compare_data("sys_rdata_o", rd, exp);
endtask

`endif

// ==== testbench/tb_rp_analog_top.sv ====
// testbench for the analog data path top level
// - clock, reset, DUT and watchdog
// - directed tests: reset and ID, LED, empty regions, levels, loopback

`timescale 1ns/1ps

module tb_rp_analog_top import rp_pkg::*; ();

  localparam int          DAT_W      = 14;
  localparam int          LED_W      = 8;
  localparam int          CLK_PERIOD = 8;   // ns
  localparam int          RST_CYCLES = 8;
  localparam int          N_TESTS    = 5;
  localparam int          N_STREAM   = 48;  // samples per loopback round
  localparam logic [31:0] LFSR_SEED  = 32'h5e7ac97f;
  localparam int          VAL_MAX    = (2 ** (DAT_W-1)) - 1;
  localparam int          VAL_MIN    = -(2 ** (DAT_W-1));

  typedef logic [DAT_W-1:0] code_t;  // adc and dac code

  logic             adc_clk = 1'b0;
  logic             rst_n_i;
  code_t            adc_dat_a_i, adc_dat_b_i;
  bus_addr_t        sys_addr_i;
  bus_data_t        sys_wdata_i;
  logic             sys_wen_i, sys_ren_i;
  bus_data_t        sys_rdata_o;
  logic             sys_ack_o, sys_err_o;
  code_t            dac_a_o, dac_b_o;
  logic [LED_W-1:0] led_o;

  // mixer state as last written
  int               lvl_a, lvl_b;
  logic [1:0]       loop_en;

  rp_analog_top #(.DAT_W(DAT_W), .LED_W(LED_W)) i_dut (
    .adc_clk     (adc_clk),     .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),   .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o),   .sys_err_o (sys_err_o),
    .dac_a_o     (dac_a_o),     .dac_b_o     (dac_b_o),     .led_o     (led_o)
  );

  always #(CLK_PERIOD/2) adc_clk = ~adc_clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_tasks.svh"

  // generous bound per test
  initial
  begin
    #(CLK_PERIOD * (RST_CYCLES + 2000 * N_TESTS));
    fail_run("timeout, the test sequence did not finish");
  end

  //////////////////////////////////////////////////
  // mixer helpers
  //////////////////////////////////////////////////

  task automatic set_loop(input logic [1:0] en);
    bus_data_t wd;
    wd      = rand_bits(32);
    wd[1:0] = en;                  // upper bits are junk
    write_ok(reg_addr(REGION_MIX, MIX_LOOP_OFS), wd);
    loop_en = en;
    read_check(reg_addr(REGION_MIX, MIX_LOOP_OFS), bus_data_t'(en));
  endtask

  // level write, dac follows one edge after the register
  task automatic set_level(input logic ch_b, input int lvl);
    bus_data_t        wd;
    code_t            old_a, old_b;
    logic [OFS_W-1:0] ofs;
    ofs   = ch_b ? MIX_LVL_B_OFS : MIX_LVL_A_OFS;
    old_a = expect_dac(lvl_a, adc_dat_a_i, loop_en[0]);
    old_b = expect_dac(lvl_b, adc_dat_b_i, loop_en[1]);
    wd    = rand_bits(32);
    wd[DAT_W-1:0] = lvl[DAT_W-1:0];  // only the low bits count
    write_ok(reg_addr(REGION_MIX, ofs), wd);
    compare_dac("dac_a_o", dac_a_o, old_a);
    compare_dac("dac_b_o", dac_b_o, old_b);
    if (ch_b)
      lvl_b = lvl;
    else
      lvl_a = lvl;
    @(negedge adc_clk);
    compare_dac("dac_a_o", dac_a_o, expect_dac(lvl_a, adc_dat_a_i, loop_en[0]));
    compare_dac("dac_b_o", dac_b_o, expect_dac(lvl_b, adc_dat_b_i, loop_en[1]));
    read_check(reg_addr(REGION_MIX, ofs), bus_data_t'(lvl));  // sign extended
  endtask

  // new adc code every cycle, two register stages to the dac
  task automatic stream_samples(input int n);
    code_t q_a[$];
    code_t q_b[$];
    code_t smp_a, smp_b;
    int    k;
    for (k = 0; k < n + 2; k++)
    begin
      @(posedge adc_clk);
      if (k < n)
      begin
        smp_a = rand_code();
        smp_b = rand_code();
        adc_dat_a_i <= smp_a;
        adc_dat_b_i <= smp_b;
        q_a.push_back(expect_dac(lvl_a, smp_a, loop_en[0]));
        q_b.push_back(expect_dac(lvl_b, smp_b, loop_en[1]));
      end
      @(negedge adc_clk);
      if (k >= 2)
      begin
        compare_dac("dac_a_o", dac_a_o, q_a.pop_front());
        compare_dac("dac_b_o", dac_b_o, q_b.pop_front());
      end
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset_id();
    @(negedge adc_clk);
    compare_flag("sys_ack_o", sys_ack_o, 1'b0);
    compare_flag("sys_err_o", sys_err_o, 1'b0);
    compare_dac("dac_a_o", dac_a_o, val_to_code(0));
    compare_dac("dac_b_o", dac_b_o, val_to_code(0));
    compare_data("led_o", bus_data_t'(led_o), '0);
    read_check(reg_addr(REGION_HK, HK_ID_OFS), HK_ID_VALUE);
    write_ok(reg_addr(REGION_HK, HK_ID_OFS), rand_bits(32));  // read only
    read_check(reg_addr(REGION_HK, HK_ID_OFS), HK_ID_VALUE);
  endtask

  task automatic test_led();
    bus_data_t wd, rd, led_exp;
    logic      err;
    repeat (4)
    begin
      wd      = rand_bits(32);
      led_exp = bus_data_t'(wd[LED_W-1:0]);
      write_ok(reg_addr(REGION_HK, HK_LED_OFS), wd);
      compare_data("led_o", bus_data_t'(led_o), led_exp);
      read_check(reg_addr(REGION_HK, HK_LED_OFS), led_exp);
    end
    // holes in the hk map
    bus_write(reg_addr(REGION_HK, 20'h04), rand_bits(32), err);
    compare_flag("sys_err_o", err, 1'b1);
    bus_read(reg_addr(REGION_HK, 20'h40), rd, err);
    compare_flag("sys_err_o", err, 1'b1);
    compare_data("sys_rdata_o", rd, '0);
  endtask

  task automatic test_empty_regions();
    bus_data_t        rd;
    logic             err;
    logic [31:0]      rnd;
    int               r;
    for (r = 0; r < N_REGIONS; r++)
    begin
      if (r == REGION_HK || r == REGION_MIX)
        continue;
      rnd = rand_bits(OFS_W);
      bus_write(reg_addr(region_t'(r), rnd[OFS_W-1:0]), rand_bits(32), err);
      compare_flag("sys_err_o", err, 1'b0);
      rnd = rand_bits(OFS_W);
      bus_read(reg_addr(region_t'(r), rnd[OFS_W-1:0]), rd, err);
      compare_flag("sys_err_o", err, 1'b0);
      compare_data("sys_rdata_o", rd, '0);
    end
  endtask

  task automatic test_levels();
    bus_data_t rd;
    logic      err;
    @(posedge adc_clk);
    adc_dat_a_i <= rand_code();    // must not reach the dac
    adc_dat_b_i <= rand_code();
    set_loop(2'b00);
    repeat (6)
    begin
      set_level(1'b0, rand_level());
      set_level(1'b1, rand_level());
    end
    bus_read(reg_addr(REGION_MIX, 20'h0C), rd, err);
    compare_flag("sys_err_o", err, 1'b1);
    compare_data("sys_rdata_o", rd, '0);
  endtask

  task automatic test_loopback();
    int r;
    for (r = 0; r < 4; r++)
    begin
      set_loop(r == 3 ? 2'b01 : 2'b11);  // last round, ch a only
      case (r)
        0:
        begin
          set_level(1'b0, VAL_MAX);      // clips high
          set_level(1'b1, VAL_MIN);      // clips low
        end
        1:
        begin
          set_level(1'b0, VAL_MIN);
          set_level(1'b1, VAL_MAX);
        end
        default:
        begin
          set_level(1'b0, rand_level());
          set_level(1'b1, rand_level());
        end
      endcase
      stream_samples(N_STREAM);
    end
  endtask

  //////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////

  initial
  begin
    rst_n_i     = 1'b0;
    adc_dat_a_i = val_to_code(0);
    adc_dat_b_i = val_to_code(0);
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    lvl_a       = 0;
    lvl_b       = 0;
    loop_en     = 2'b00;
    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    test_reset_id();
    test_led();
    test_empty_regions();
    test_levels();
    test_loopback();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== rp_analog_top.f ====
+incdir+testbench
logic/rp_pkg.sv
logic/sys_bus_if.sv
logic/sys_bus_decoder.sv
logic/housekeeping_regs.sv
logic/adc_frontend.sv
logic/dac_mix_regs.sv
logic/dac_output.sv
logic/rp_analog_top.sv
testbench/tb_rp_analog_top.sv

// ==== Makefile ====
TOP = tb_rp_analog_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): rp_analog_top.f logic/*.sv testbench/*.sv testbench/*.svh
	verilator --binary --timing -j 0 -Wno-fatal -f rp_analog_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f rp_analog_top.f --top-module rp_analog_top

clean:
	rm -rf obj_dir
